/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP      = score_display_tb
FILELIST = score_display.f

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^Simulation PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* hdl/char_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module char_rom (
    input  wire                 pclk,
    input  wire vga_pkg::char_code_t char_code,
    input  wire  [3:0]          char_line,
    output logic [7:0]          char_row
);

    localparam logic [7:0] BAR   = 8'b0111_1100;
    localparam logic [7:0] LEFT  = 8'b0100_0000;
    localparam logic [7:0] RIGHT = 8'b0000_0100;
    localparam logic [7:0] STEM  = 8'b0001_1000;

    logic       is_digit;
    logic [6:0] seg;                        // {g,f,e,d,c,b,a}
    logic [7:0] glyph_row;

    assign is_digit = (char_code[6:4] == vga_pkg::CODE_ZERO[6:4]) && (char_code[3:0] <= 4'd9);

    always_comb begin
        case (char_code[3:0])
            4'd0:    seg = 7'h3f;
            4'd1:    seg = 7'h06;
            4'd2:    seg = 7'h5b;
            4'd3:    seg = 7'h4f;
            4'd4:    seg = 7'h66;
            4'd5:    seg = 7'h6d;
            4'd6:    seg = 7'h7d;
            4'd7:    seg = 7'h07;
            4'd8:    seg = 7'h7f;
            default: seg = 7'h6f;
        endcase
    end

    always_comb begin
        glyph_row = 8'h00;
        if (is_digit) begin
            case (char_line)
                4'd2:                   glyph_row = seg[0] ? BAR : 8'h00;
                4'd3, 4'd4, 4'd5, 4'd6: glyph_row = (seg[5] ? LEFT : 8'h00) | (seg[1] ? RIGHT : 8'h00);
                4'd7:                   glyph_row = seg[6] ? BAR :
                                                    ((seg[5] | seg[4]) ? LEFT : 8'h00) |
                                                    ((seg[1] | seg[2]) ? RIGHT : 8'h00);
                4'd8, 4'd9, 4'd10, 4'd11: glyph_row = (seg[4] ? LEFT : 8'h00) | (seg[2] ? RIGHT : 8'h00);
                4'd12:                  glyph_row = seg[3] ? BAR : 8'h00;
                default:                glyph_row = 8'h00;
            endcase
        end else if (char_code == vga_pkg::CODE_MARK) begin
            if ((char_line >= 4'd2 && char_line <= 4'd8) || char_line == 4'd11 || char_line == 4'd12) begin
                glyph_row = STEM;           // Bar with a dot below
            end
        end
    end

    always_ff @(posedge pclk) begin
        char_row <= glyph_row;
    end

endmodule

`default_nettype wire

/* hdl/pipe_delay.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_delay #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 1
) (
    input  wire              pclk,
    input  wire              rst,
    input  wire  [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stage [DEPTH];

    always_ff @(posedge pclk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

/* hdl/playfield_bg.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module playfield_bg (
    input  wire               pclk,
    input  wire               rst,
    input  wire vga_pkg::vga_bus_t vga_in,
    output vga_pkg::vga_bus_t vga_out
);

    logic        on_border;
    logic [11:0] bg_rgb;

    assign on_border = (vga_in.hcount < `FRAME_W) ||
                       (vga_in.hcount >= `H_ACTIVE - `FRAME_W) ||
                       (vga_in.vcount < `FRAME_W) ||
                       (vga_in.vcount >= `V_ACTIVE - `FRAME_W);

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            bg_rgb = 12'h000;               // Black outside active video
        end else if (on_border) begin
            bg_rgb = `FRAME_RGB;
        end else begin
            bg_rgb = `FIELD_RGB;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= bg_rgb;
        end
    end

endmodule

`default_nettype wire

/* hdl/score_display.sv */
`timescale 1ns/100ps
`default_nettype none

module score_display (
    input  wire               pclk,
    input  wire               rst,
    input  wire  [3:0]        score_l_hi,
    input  wire  [3:0]        score_l_lo,
    input  wire  [3:0]        score_r_hi,
    input  wire  [3:0]        score_r_lo,
    input  wire               point_flag,
    output vga_pkg::vga_bus_t vga_out
);

    vga_pkg::vga_bus_t   timing_bus;
    vga_pkg::vga_bus_t   bg_bus;
    vga_pkg::char_code_t code_l;
    vga_pkg::char_code_t code_r;
    logic [3:0]          char_line;
    logic [7:0]          row_l;
    logic [7:0]          row_r;

    vga_timing vga_timing_i (
        .pclk(pclk),
        .rst (rst),
        .vga (timing_bus)
    );

    playfield_bg playfield_bg_i (
        .pclk   (pclk),
        .rst    (rst),
        .vga_in (timing_bus),
        .vga_out(bg_bus)
    );

    score_overlay score_overlay_i (
        .pclk      (pclk),
        .rst       (rst),
        .vga_in    (bg_bus),
        .vga_out   (vga_out),
        .score_l_hi(score_l_hi),
        .score_l_lo(score_l_lo),
        .score_r_hi(score_r_hi),
        .score_r_lo(score_r_lo),
        .point_flag(point_flag),
        .row_l     (row_l),
        .row_r     (row_r),
        .char_line (char_line),
        .code_l    (code_l),
        .code_r    (code_r)
    );

    char_rom char_rom_l (
        .pclk     (pclk),
        .char_code(code_l),
        .char_line(char_line),
        .char_row (row_l)
    );

    char_rom char_rom_r (
        .pclk     (pclk),
        .char_code(code_r),
        .char_line(char_line),
        .char_row (row_r)
    );

endmodule

`default_nettype wire

/* hdl/score_overlay.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module score_overlay (
    input  wire                  pclk,
    input  wire                  rst,
    input  wire vga_pkg::vga_bus_t vga_in,
    output vga_pkg::vga_bus_t    vga_out,
    input  wire  [3:0]           score_l_hi,
    input  wire  [3:0]           score_l_lo,
    input  wire  [3:0]           score_r_hi,
    input  wire  [3:0]           score_r_lo,
    input  wire                  point_flag,
    input  wire  [7:0]           row_l,
    input  wire  [7:0]           row_r,
    output logic [3:0]           char_line,
    output vga_pkg::char_code_t  code_l,
    output vga_pkg::char_code_t  code_r
);

    vga_pkg::vga_bus_t   bus_d;
    vga_pkg::char_code_t code_l_nxt;
    vga_pkg::char_code_t code_r_nxt;
    vga_pkg::char_code_t mark_l;
    vga_pkg::char_code_t mark_r;
    logic [2:0]          col;
    logic                in_left;
    logic                in_right;
    logic [11:0]         pix_rgb;

    function automatic logic in_box(input logic [11:0] h, input logic [11:0] v, input int x);
        return (h >= x) && (h <= x + `BOX_W) && (v >= `BOX_Y) && (v <= `BOX_Y + `BOX_H);
    endfunction

    function automatic vga_pkg::char_code_t digit_code(input logic [3:0] d);
        return vga_pkg::CODE_ZERO + {3'b000, d};
    endfunction

    // The mark sits on the side of the player who scored last
    assign mark_l = point_flag ? vga_pkg::CODE_BLANK : vga_pkg::CODE_MARK;
    assign mark_r = point_flag ? vga_pkg::CODE_MARK : vga_pkg::CODE_BLANK;

    always_comb begin
        case (vga_in.hcount[6:5])
            2'd0: begin
                code_l_nxt = digit_code(score_l_hi);
                code_r_nxt = vga_pkg::CODE_BLANK;
            end
            2'd1: begin
                code_l_nxt = digit_code(score_l_lo);
                code_r_nxt = mark_r;
            end
            2'd2: begin
                code_l_nxt = mark_l;
                code_r_nxt = digit_code(score_r_hi);
            end
            default: begin
                code_l_nxt = vga_pkg::CODE_BLANK;
                code_r_nxt = digit_code(score_r_lo);
            end
        endcase
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            code_l    <= vga_pkg::CODE_BLANK;
            code_r    <= vga_pkg::CODE_BLANK;
            char_line <= '0;
        end else begin
            code_l    <= code_l_nxt;
            code_r    <= code_r_nxt;
            char_line <= vga_in.vcount[5:2];
        end
    end

    // Bus waits for the code register and the ROM register
    pipe_delay #(
        .WIDTH($bits(vga_pkg::vga_bus_t)),
        .DEPTH(`OVERLAY_LATENCY)
    ) bus_delay_i (
        .pclk(pclk),
        .rst (rst),
        .din (vga_in),
        .dout(bus_d)
    );

    assign col      = bus_d.hcount[4:2];    // Each glyph pixel is 4x4 screen pixels
    assign in_left  = in_box(bus_d.hcount, bus_d.vcount, `BOX_LEFT_X);
    assign in_right = in_box(bus_d.hcount, bus_d.vcount, `BOX_RIGHT_X);

    always_comb begin
        if (in_left) begin
            pix_rgb = row_l[3'd7 - col] ? `TEXT_RGB : `BOX_RGB;
        end else if (in_right) begin
            pix_rgb = row_r[3'd7 - col] ? `TEXT_RGB : `BOX_RGB;
        end else begin
            pix_rgb = bus_d.rgb;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= bus_d;
            vga_out.rgb <= pix_rgb;
        end
    end

    a_bcd_digits: assert property (
        @(posedge pclk) disable iff (rst)
        (score_l_hi <= 4'd9) && (score_l_lo <= 4'd9) &&
        (score_r_hi <= 4'd9) && (score_r_lo <= 4'd9)
    );

endmodule

`default_nettype wire

/* hdl/vga_defines.svh */
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

// 1024x768 at 60 Hz, sync active high
`define H_ACTIVE        1024
`define H_TOTAL         1344
`define H_SYNC_START    1048
`define H_SYNC_END      1184
`define V_ACTIVE        768
`define V_TOTAL         806
`define V_SYNC_START    771
`define V_SYNC_END      777

`define BOX_LEFT_X      1
`define BOX_RIGHT_X     922
`define BOX_Y           0
`define BOX_W           100
`define BOX_H           50

`define FRAME_W         4       // Border thickness in pixels

`define TEXT_RGB        12'hf_f_3
`define BOX_RGB         12'h3be
`define FIELD_RGB       12'h060
`define FRAME_RGB       12'hfff

`define OVERLAY_LATENCY 2

`endif

/* hdl/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    typedef struct packed {
        logic [11:0] hcount;
        logic [11:0] vcount;
        logic        hsync;
        logic        hblnk;
        logic        vsync;
        logic        vblnk;
        logic [11:0] rgb;   // 4:4:4
    } vga_bus_t;

    typedef logic [6:0] char_code_t;

    // Codes understood by char_rom
    localparam char_code_t CODE_BLANK = 7'h00;
    localparam char_code_t CODE_MARK  = 7'h21;
    localparam char_code_t CODE_ZERO  = 7'h30;

endpackage

`default_nettype wire

/* hdl/vga_timing.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module vga_timing (
    input  wire              pclk,
    input  wire              rst,
    output vga_pkg::vga_bus_t vga
);

    logic [11:0] h_cnt;
    logic [11:0] v_cnt;
    logic        h_last;
    logic        v_last;

    assign h_last = (h_cnt == 12'(`H_TOTAL - 1));
    assign v_last = (v_cnt == 12'(`V_TOTAL - 1));

    always_ff @(posedge pclk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                v_cnt <= '0;                // New frame
            end else begin
                v_cnt <= v_cnt + 12'd1;
            end
        end else begin
            h_cnt <= h_cnt + 12'd1;
        end
    end

    always_comb begin
        vga.hcount = h_cnt;
        vga.vcount = v_cnt;
        vga.hsync  = (h_cnt >= `H_SYNC_START) && (h_cnt < `H_SYNC_END);
        vga.hblnk  = (h_cnt >= `H_ACTIVE);
        vga.vsync  = (v_cnt >= `V_SYNC_START) && (v_cnt < `V_SYNC_END);
        vga.vblnk  = (v_cnt >= `V_ACTIVE);
        vga.rgb    = '0;                    // Painted further down the chain
    end

    a_hcount_range: assert property (
        @(posedge pclk) disable iff (rst)
        h_cnt < `H_TOTAL
    );

endmodule

`default_nettype wire

/* score_display.f */
+incdir+hdl
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/pipe_delay.sv
hdl/playfield_bg.sv
hdl/char_rom.sv
hdl/score_overlay.sv
hdl/score_display.sv
tests/score_checker.sv
tests/score_display_tb.sv

/* tests/score_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module score_checker (
    input  wire                    pclk,
    input  wire                    rst,
    input  wire vga_pkg::vga_bus_t vga_out,
    input  wire  [11:0]            probe_h,
    input  wire  [11:0]            probe_v,
    input  wire  [11:0]            probe_rgb,
    input  wire                    probe_valid,
    output logic                   probe_done,
    output int                     value_errs,
    output int                     missed,
    output int                     timing_errs
);

    int          cycles       = 0;      // Saturating count of samples since reset release
    int          frame_starts = 0;
    int          n_value      = 0;
    int          n_missed     = 0;
    int          n_timing     = 0;
    logic [11:0] prev_h       = '0;
    logic [11:0] prev_v       = '0;
    logic        done         = 1'b0;
    logic [11:0] expect_h;
    logic [11:0] expect_v;
    logic [3:0]  expect_flags;          // {hsync, hblnk, vsync, vblnk}
    logic        expect_blank;
    logic        live;
    logic        at_probe;

    assign probe_done  = done;
    assign value_errs  = n_value;
    assign missed      = n_missed;
    assign timing_errs = n_timing;

    // Pixel (0,0) reaches the output on the 4th edge after release
    assign live     = (cycles >= 3);
    assign expect_h = (cycles == 3) ? 12'd0 :
                      (prev_h == 12'(`H_TOTAL - 1)) ? 12'd0 : prev_h + 12'd1;
    assign expect_v = (cycles == 3) ? 12'd0 :
                      (prev_h != 12'(`H_TOTAL - 1)) ? prev_v :
                      (prev_v == 12'(`V_TOTAL - 1)) ? 12'd0 : prev_v + 12'd1;
    assign expect_flags = {(expect_h >= `H_SYNC_START) && (expect_h < `H_SYNC_END),
                           (expect_h >= `H_ACTIVE),
                           (expect_v >= `V_SYNC_START) && (expect_v < `V_SYNC_END),
                           (expect_v >= `V_ACTIVE)};
    assign expect_blank = expect_flags[2] || expect_flags[0];
    assign at_probe = live && (vga_out.hcount == probe_h) && (vga_out.vcount == probe_v);

    always @(negedge pclk) begin
        if (rst) begin
            cycles <= 0;
        end else if (cycles < 4) begin
            cycles <= cycles + 1;
        end
        prev_h <= vga_out.hcount;
        prev_v <= vga_out.vcount;

        if (!live && vga_out != '0) begin
            $display("ERR %0t vga_out expected %h got %h", $time, 42'h0, vga_out);
            n_timing <= n_timing + 1;
        end else if (live && vga_out.hcount != expect_h) begin
            $display("ERR %0t vga_out.hcount expected %0d got %0d",
                     $time, expect_h, vga_out.hcount);
            n_timing <= n_timing + 1;
        end else if (live && vga_out.vcount != expect_v) begin
            $display("ERR %0t vga_out.vcount expected %0d got %0d",
                     $time, expect_v, vga_out.vcount);
            n_timing <= n_timing + 1;
        end else if (live && {vga_out.hsync, vga_out.hblnk, vga_out.vsync, vga_out.vblnk}
                             != expect_flags) begin
            $display("ERR %0t vga_out.{hsync,hblnk,vsync,vblnk} expected %b got %b",
                     $time, expect_flags,
                     {vga_out.hsync, vga_out.hblnk, vga_out.vsync, vga_out.vblnk});
            n_timing <= n_timing + 1;
        end
        if (live && expect_blank && vga_out.rgb != 12'h000) begin
            $display("ERR %0t vga_out.rgb expected %h got %h", $time, 12'h000, vga_out.rgb);
            n_value <= n_value + 1;
        end

        if (!probe_valid) begin
            done         <= 1'b0;
            frame_starts <= 0;
        end else if (!done && at_probe) begin
            if (vga_out.rgb !== probe_rgb) begin
                $display("ERR %0t vga_out.rgb at (%0d,%0d) expected %h got %h",
                         $time, probe_h, probe_v, probe_rgb, vga_out.rgb);
                n_value <= n_value + 1;
            end
            done <= 1'b1;
        end else if (!done && live && vga_out.hcount == 0 && vga_out.vcount == 0) begin
            if (frame_starts > 0) begin
                $display("Probe at pixel (%0d,%0d) was not reached within two frames",
                         probe_h, probe_v);
                n_missed <= n_missed + 1;
                done     <= 1'b1;
            end
            frame_starts <= frame_starts + 1;
        end
    end

endmodule

`default_nettype wire

/* tests/score_display_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module score_display_tb;

    logic              pclk;
    logic              rst;
    logic [3:0]        score_l_hi;
    logic [3:0]        score_l_lo;
    logic [3:0]        score_r_hi;
    logic [3:0]        score_r_lo;
    logic              point_flag;
    vga_pkg::vga_bus_t vga_out;
    logic [11:0]       probe_h;
    logic [11:0]       probe_v;
    logic [11:0]       probe_rgb;
    logic              probe_valid;
    logic              probe_done;
    int                value_errs;
    int                missed;
    int                timing_errs;
    int                num_scen = 0;
    logic [16:0]       scen_q [$];      // {l_hi, l_lo, r_hi, r_lo, flag}
    int                count_q [$];
    logic [35:0]       probe_q [$];     // {h, v, rgb}

    score_display score_display_i (
        .pclk      (pclk),
        .rst       (rst),
        .score_l_hi(score_l_hi),
        .score_l_lo(score_l_lo),
        .score_r_hi(score_r_hi),
        .score_r_lo(score_r_lo),
        .point_flag(point_flag),
        .vga_out   (vga_out)
    );

    score_checker score_checker_i (
        .pclk       (pclk),
        .rst        (rst),
        .vga_out    (vga_out),
        .probe_h    (probe_h),
        .probe_v    (probe_v),
        .probe_rgb  (probe_rgb),
        .probe_valid(probe_valid),
        .probe_done (probe_done),
        .value_errs (value_errs),
        .missed     (missed),
        .timing_errs(timing_errs)
    );

    initial begin
        pclk = 1'b0;
        forever #10 pclk = ~pclk;
    end

    task automatic load_patterns();
        int    fd;
        int    left;
        int    n;
        int    h;
        int    v;
        int    rgb;
        int    d [5];
        string line;
        fd = $fopen("tests/score_patterns.txt", "r");
        if (fd == 0) begin
            return;
        end
        left = 0;
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (left == 0) begin
                if ($sscanf(line, "%d %d %d %d %d %d", d[0], d[1], d[2], d[3], d[4], n) == 6) begin
                    scen_q.push_back({d[0][3:0], d[1][3:0], d[2][3:0], d[3][3:0], d[4][0]});
                    count_q.push_back(n);
                    left = n;
                end
            end else if ($sscanf(line, "%d %d %h", h, v, rgb) == 3) begin
                probe_q.push_back({h[11:0], v[11:0], rgb[11:0]});
                left--;
            end
        end
        $fclose(fd);
        num_scen = scen_q.size();
    endtask

    // Arm one probe and wait until the checker has seen it or given up on it
    task automatic apply_probe(input logic [35:0] p);
        {probe_h, probe_v, probe_rgb} <= p;
        probe_valid <= 1'b1;
        do @(negedge pclk); while (!probe_done);
        probe_valid <= 1'b0;
        do @(negedge pclk); while (probe_done);
    endtask

    initial begin
        int pi;
        rst         = 1'b1;
        score_l_hi  = 4'd0;
        score_l_lo  = 4'd0;
        score_r_hi  = 4'd0;
        score_r_lo  = 4'd0;
        point_flag  = 1'b0;
        probe_h     = '0;
        probe_v     = '0;
        probe_rgb   = '0;
        probe_valid = 1'b0;
        pi          = 0;
        load_patterns();
        repeat (8) @(negedge pclk);
        rst <= 1'b0;
        for (int s = 0; s < num_scen; s++) begin
            do @(negedge pclk); while (!vga_out.vblnk);     // Scores move between frames
            {score_l_hi, score_l_lo, score_r_hi, score_r_lo, point_flag} <= scen_q[s];
            for (int k = 0; k < count_q[s]; k++) begin
                apply_probe(probe_q[pi]);
                pi++;
            end
        end
        repeat (2) @(negedge pclk);
        if (num_scen == 0) begin
            $display("No score scenarios could be read from tests/score_patterns.txt");
        end
        $display("Error counts: pixel %0d, missed probe %0d, timing %0d",
                 value_errs, missed, timing_errs);
        if (num_scen > 0 && value_errs + missed + timing_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        longint limit_ns;
        wait (num_scen > 0);
        limit_ns = longint'(num_scen + 2) * `H_TOTAL * `V_TOTAL * 20;
        #(limit_ns);
        $display("Watchdog expired after %0d ns with probes still pending", limit_ns);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/score_patterns.txt */
# scenario: left_hi left_lo right_hi right_lo point_flag probe_count
#   probe:  hcount vcount expected_rgb (hex), listed in raster order
1 2 3 4 0 8
  44 9 ff3
  21 16 ff3
  77 20 ff3
  941 20 3be
  970 29 ff3
  1000 49 3be
  0 300 fff
  500 400 060
1 2 3 4 1 4
  77 20 3be
  941 20 ff3
  1100 100 000
  600 790 000
9 0 5 7 0 4
  45 30 3be
  53 30 ff3
  1013 37 ff3
  10 48 ff3
0 8 6 5 1 6
  1 0 3be
  0 2 fff
  965 17 ff3
  981 17 3be
  101 20 3be
  102 24 060
